// File: tb.f
+incdir+include
source/mem_cfg_pkg.sv
source/cache_dma_pkg.sv
source/core_reset_ctr.sv
source/dram_cfg_regs.sv
source/dma_fifo.sv
source/cache_dma_bridge.sv
source/dram_bank.sv
source/mem_subsys_top.sv
verif/mem_subsys_tb.sv

// File: verif/mem_subsys_tb.sv
/*
  Directed testbench for the two-channel memory subsystem.
  Byte addresses stay below 4 KiB, so bank word indices never alias.
  Read latency changes only while both channels are idle.
  Inputs change 1 ns after the rising edge. Outputs are sampled 3 ns later.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_tb
  import mem_cfg_pkg::*;
  import cache_dma_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int BLK            = `MEM_BLOCK_WORDS;
  localparam int WORD_BYTES     = `MEM_DATA_W / 8;

  logic                   core_clk;
  logic                   rst_n_i;
  logic                   cfg_req;
  logic                   cfg_we;
  cfg_addr_t              cfg_addr;
  logic [`MEM_DATA_W-1:0] cfg_wdata;
  wire                    cfg_ack;
  wire  [`MEM_DATA_W-1:0] cfg_rdata;
  wire  [31:0]            cycle_ctr;

  // index 0 is north, 1 is south
  logic [1:0]                  pkt_v;
  dma_pkt_t [1:0]              pkt;
  logic [1:0]                  wdata_v;
  dma_word_t [1:0]             wdata;
  logic [1:0]                  rdata_ready;
  wire  [1:0]                  pkt_yumi;
  wire  [1:0]                  wdata_yumi;
  wire  [1:0]                  rdata_v;
  wire  [1:0][`MEM_DATA_W-1:0] rdata;

  dma_word_t   model [2][`MEM_BANK_WORDS];
  logic [15:0] lfsr_q;
  int          cycles;
  int          n_yumi_cnt;

  mem_subsys_top u_mem_subsys_top (
    .core_clk           (core_clk),
    .rst_n_i            (rst_n_i),
    .cfg_req_i          (cfg_req),
    .cfg_we_i           (cfg_we),
    .cfg_addr_i         (cfg_addr),
    .cfg_wdata_i        (cfg_wdata),
    .cfg_ack_o          (cfg_ack),
    .cfg_rdata_o        (cfg_rdata),
    .cycle_ctr_o        (cycle_ctr),
    .n_dma_pkt_v_i      (pkt_v[0]),
    .n_dma_pkt_i        (pkt[0]),
    .n_dma_pkt_yumi_o   (pkt_yumi[0]),
    .n_dma_wdata_v_i    (wdata_v[0]),
    .n_dma_wdata_i      (wdata[0]),
    .n_dma_wdata_yumi_o (wdata_yumi[0]),
    .n_dma_rdata_v_o    (rdata_v[0]),
    .n_dma_rdata_o      (rdata[0]),
    .n_dma_rdata_ready_i(rdata_ready[0]),
    .s_dma_pkt_v_i      (pkt_v[1]),
    .s_dma_pkt_i        (pkt[1]),
    .s_dma_pkt_yumi_o   (pkt_yumi[1]),
    .s_dma_wdata_v_i    (wdata_v[1]),
    .s_dma_wdata_i      (wdata[1]),
    .s_dma_wdata_yumi_o (wdata_yumi[1]),
    .s_dma_rdata_v_o    (rdata_v[1]),
    .s_dma_rdata_o      (rdata[1]),
    .s_dma_rdata_ready_i(rdata_ready[1])
  );

  always #5 core_clk = ~core_clk;

  always @(posedge core_clk) cycles <= cycles + 1;

  // north packet acceptances, sampled mid-cycle
  always @(negedge core_clk) begin
    if (pkt_yumi[0]) n_yumi_cnt <= n_yumi_cnt + 1;
  end

  initial begin
    wait (cycles >= TIMEOUT_CYCLES);
    $display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "simulation stopped by timeout");
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    return b;
  endfunction

  function automatic dma_word_t take_word();
    dma_word_t w;
    for (int i = 0; i < `MEM_DATA_W; i++) begin
      w[i] = take_bit();
    end
    return w;
  endfunction

  // first word of the block that holds this byte address
  function automatic int block_base(input logic [`MEM_ADDR_W-1:0] a);
    return ((int'(a) / WORD_BYTES) / BLK * BLK) % `MEM_BANK_WORDS;
  endfunction

  task automatic value_error(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic next_cycle();
    @(posedge core_clk);
    #1;
  endtask

  task automatic cfg_access(input logic we, input cfg_addr_t addr,
                            input logic [`MEM_DATA_W-1:0] wd,
                            output logic [`MEM_DATA_W-1:0] rd);
    logic acked;
    acked     = 1'b0;
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wd;
    while (!acked) begin
      #3;
      acked = cfg_ack;
      rd    = cfg_rdata;
      next_cycle();
    end
    cfg_req = 1'b0;
    while (acked) begin
      #3;
      acked = cfg_ack;
      next_cycle();
    end
    cfg_we = 1'b0;
  endtask

  task automatic cfg_check(input logic we, input cfg_addr_t addr,
                           input logic [`MEM_DATA_W-1:0] wd,
                           input logic [`MEM_DATA_W-1:0] exp);
    logic [`MEM_DATA_W-1:0] rd;
    cfg_access(we, addr, wd, rd);
    assert (rd === exp) else value_error($sformatf(
      "cfg addr %0d read %0h, expected %0h", addr, rd, exp));
  endtask

  task automatic send_packet(input int ch, input logic we,
                             input logic [`MEM_ADDR_W-1:0] addr);
    logic taken;
    taken                  = 1'b0;
    pkt_v[ch]              = 1'b1;
    pkt[ch].write_not_read = we;
    pkt[ch].addr           = addr;
    while (!taken) begin
      #3;
      taken = pkt_yumi[ch];
      next_cycle();
    end
    pkt_v[ch] = 1'b0;
  endtask

  task automatic write_block(input int ch, input logic [`MEM_ADDR_W-1:0] addr);
    int   base;
    logic taken;
    base = block_base(addr);
    send_packet(ch, 1'b1, addr);
    for (int beat = 0; beat < BLK; beat++) begin
      wdata_v[ch]             = 1'b1;
      wdata[ch]               = take_word();
      model[ch][base + beat]  = wdata[ch];
      taken                   = 1'b0;
      while (!taken) begin
        #3;
        taken = wdata_yumi[ch];
        next_cycle();
      end
    end
    wdata_v[ch] = 1'b0;
  endtask

  task automatic collect_block(input int ch, input logic [`MEM_ADDR_W-1:0] addr,
                               input logic rand_ready);
    int base;
    int got;
    base = block_base(addr);
    got  = 0;
    while (got < BLK) begin
      rdata_ready[ch] = rand_ready ? take_bit() : 1'b1;
      #3;
      if (rdata_v[ch] && rdata_ready[ch]) begin
        assert (rdata[ch] === model[ch][base + got]) else value_error($sformatf(
          "ch %0d beat %0d read %h, expected %h", ch, got, rdata[ch],
          model[ch][base + got]));
        got++;
      end
      next_cycle();
    end
    // a further beat here would be a duplicate
    rdata_ready[ch] = 1'b1;
    repeat (`MEM_LAT_MAX + 2) begin
      #3;
      assert (!rdata_v[ch]) else value_error($sformatf(
        "ch %0d returned a beat after its block ended", ch));
      next_cycle();
    end
    rdata_ready[ch] = 1'b0;
  endtask

  // first beat cannot show up before the bank latency has passed
  task automatic check_read_delay(input int ch, input int lat);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen) begin
      #3;
      seen = rdata_v[ch];
      next_cycle();
      if (!seen) waited++;
    end
    assert (waited >= lat - 1) else value_error($sformatf(
      "ch %0d first read beat after %0d cycles at latency %0d", ch, waited, lat));
  endtask

  task automatic read_block(input int ch, input logic [`MEM_ADDR_W-1:0] addr,
                            input logic rand_ready);
    send_packet(ch, 1'b0, addr);
    collect_block(ch, addr, rand_ready);
  endtask

  task automatic test_idle();
    logic [31:0] exp_ctr;
    exp_ctr = 32'd0;
    #3;
    assert (cycle_ctr === exp_ctr) else value_error($sformatf(
      "cycle counter read %0d after reset, expected 0", cycle_ctr));
    next_cycle();
    repeat (12) begin
      exp_ctr = exp_ctr + 32'd1;
      #3;
      assert (pkt_yumi === 2'b00 && wdata_yumi === 2'b00 && rdata_v === 2'b00
              && cfg_ack === 1'b0)
        else value_error("handshake output active with no request");
      assert (cycle_ctr === exp_ctr) else value_error($sformatf(
        "cycle counter read %0d, expected %0d", cycle_ctr, exp_ctr));
      next_cycle();
    end
  endtask

  task automatic test_cfg();
    cfg_check(1'b1, CFG_ADDR_RD_LAT, 32'd5, 32'd5);
    cfg_check(1'b1, CFG_ADDR_CHAN_EN, 32'd2, 32'd2);
    cfg_check(1'b1, CFG_ADDR_CHAN_EN, 32'd3, 32'd3);
    // latency saturates at both ends
    cfg_check(1'b1, CFG_ADDR_RD_LAT, 32'd0, 32'd1);
    cfg_check(1'b1, CFG_ADDR_RD_LAT, 32'd100, `MEM_LAT_MAX);
    cfg_check(1'b0, CFG_ADDR_RD_LAT, 32'd0, `MEM_LAT_MAX);
    cfg_check(1'b1, cfg_addr_t'(2), 32'hffff, 32'd0);
    cfg_check(1'b0, cfg_addr_t'(3), 32'd0, 32'd0);
    cfg_check(1'b1, CFG_ADDR_RD_LAT, 32'd1, 32'd1);
  endtask

  task automatic test_disabled_north();
    int   start;
    int   yumi_before;
    logic acked;
    logic taken;
    cfg_check(1'b1, CFG_ADDR_CHAN_EN, 32'd2, 32'd2);
    yumi_before         = n_yumi_cnt;
    start               = cycles;
    pkt_v[0]            = 1'b1;
    pkt[0].write_not_read = 1'b0;
    pkt[0].addr         = 14'h0123;
    write_block(1, 14'h0800);
    read_block(1, 14'h0800, 1'b0);
    while (cycles - start < 20) next_cycle();
    assert (n_yumi_cnt == yumi_before)
      else value_error("north packet accepted while its channel was disabled");
    // re-enable north while the packet is still offered
    cfg_req   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = CFG_ADDR_CHAN_EN;
    cfg_wdata = 32'd3;
    acked     = 1'b0;
    taken     = 1'b0;
    while (!taken || cfg_req || acked) begin
      #3;
      acked = cfg_ack;
      if (pkt_yumi[0]) taken = 1'b1;
      next_cycle();
      if (taken) pkt_v[0] = 1'b0;
      if (acked) cfg_req = 1'b0;
    end
    cfg_we = 1'b0;
    collect_block(0, 14'h0123, 1'b0);
  endtask

  task automatic test_latency(input int lat, input logic [`MEM_ADDR_W-1:0] addr);
    cfg_check(1'b1, CFG_ADDR_RD_LAT, lat, lat);
    write_block(0, addr);
    send_packet(0, 1'b0, addr);
    check_read_delay(0, lat);
    collect_block(0, addr, 1'b1);
    write_block(1, addr + 14'h0010);
    read_block(1, addr + 14'h0010, 1'b1);
    read_block(0, 14'h0123, 1'b1);
  endtask

  initial begin
    core_clk    = 1'b0;
    rst_n_i     = 1'b0;
    cfg_req     = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    pkt_v       = '0;
    pkt         = '0;
    wdata_v     = '0;
    wdata       = '0;
    rdata_ready = '0;
    lfsr_q      = 16'd44832;
    cycles      = 0;
    n_yumi_cnt  = 0;
    repeat (5) @(posedge core_clk);
    #1;
    rst_n_i = 1'b1;
    // internal reset trails by the pipeline depth
    repeat (`MEM_RESET_STAGES) next_cycle();
    test_idle();
    test_cfg();
    write_block(0, 14'h0123);
    read_block(0, 14'h0127, 1'b0);
    write_block(0, 14'h0400);
    write_block(1, 14'h0400);
    read_block(0, 14'h0400, 1'b0);
    read_block(1, 14'h0400, 1'b0);
    test_disabled_north();
    test_latency(1, 14'h0a04);
    test_latency(`MEM_LAT_MAX, 14'h0c08);
    $display("Test OK");
    $finish;
  end

endmodule

// File: source/mem_subsys_top.sv
/*
  Memory side of the test harness. Two independent channels, north and
  south, each a DMA bridge in front of its own bank. The configuration
  port sets the shared read latency and the per-channel enables.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_top import mem_cfg_pkg::*; import cache_dma_pkg::*; (
  input  logic                   core_clk,
  input  logic                   rst_n_i,
  input  logic                   cfg_req_i,
  input  logic                   cfg_we_i,
  input  cfg_addr_t              cfg_addr_i,
  input  logic [`MEM_DATA_W-1:0] cfg_wdata_i,
  output logic                   cfg_ack_o,
  output logic [`MEM_DATA_W-1:0] cfg_rdata_o,
  output logic [31:0]            cycle_ctr_o,
  input  logic                   n_dma_pkt_v_i,
  input  dma_pkt_t               n_dma_pkt_i,
  output logic                   n_dma_pkt_yumi_o,
  input  logic                   n_dma_wdata_v_i,
  input  dma_word_t              n_dma_wdata_i,
  output logic                   n_dma_wdata_yumi_o,
  output logic                   n_dma_rdata_v_o,
  output dma_word_t              n_dma_rdata_o,
  input  logic                   n_dma_rdata_ready_i,
  input  logic                   s_dma_pkt_v_i,
  input  dma_pkt_t               s_dma_pkt_i,
  output logic                   s_dma_pkt_yumi_o,
  input  logic                   s_dma_wdata_v_i,
  input  dma_word_t              s_dma_wdata_i,
  output logic                   s_dma_wdata_yumi_o,
  output logic                   s_dma_rdata_v_o,
  output dma_word_t              s_dma_rdata_o,
  input  logic                   s_dma_rdata_ready_i
);

  logic       sys_rst_n;
  rd_lat_t    rd_lat;
  chan_en_t   chan_en;

  logic       n_bank_req;
  logic       n_bank_we;
  bank_addr_t n_bank_addr;
  dma_word_t  n_bank_wdata;
  logic       n_bank_rdata_v;
  dma_word_t  n_bank_rdata;

  logic       s_bank_req;
  logic       s_bank_we;
  bank_addr_t s_bank_addr;
  dma_word_t  s_bank_wdata;
  logic       s_bank_rdata_v;
  dma_word_t  s_bank_rdata;

  core_reset_ctr u_core_reset_ctr (
    .core_clk   (core_clk),
    .rst_n_i    (rst_n_i),
    .sys_rst_n_o(sys_rst_n),
    .cycle_ctr_o(cycle_ctr_o)
  );

  dram_cfg_regs u_dram_cfg_regs (
    .core_clk   (core_clk),
    .rst_n_i    (sys_rst_n),
    .cfg_req_i  (cfg_req_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .cfg_ack_o  (cfg_ack_o),
    .cfg_rdata_o(cfg_rdata_o),
    .rd_lat_o   (rd_lat),
    .chan_en_o  (chan_en)
  );

  // north channel
  cache_dma_bridge u_bridge_n (
    .core_clk         (core_clk),
    .rst_n_i          (sys_rst_n),
    .chan_en_i        (chan_en[CHAN_N]),
    .dma_pkt_v_i      (n_dma_pkt_v_i),
    .dma_pkt_i        (n_dma_pkt_i),
    .dma_pkt_yumi_o   (n_dma_pkt_yumi_o),
    .dma_wdata_v_i    (n_dma_wdata_v_i),
    .dma_wdata_i      (n_dma_wdata_i),
    .dma_wdata_yumi_o (n_dma_wdata_yumi_o),
    .dma_rdata_v_o    (n_dma_rdata_v_o),
    .dma_rdata_o      (n_dma_rdata_o),
    .dma_rdata_ready_i(n_dma_rdata_ready_i),
    .bank_req_o       (n_bank_req),
    .bank_we_o        (n_bank_we),
    .bank_addr_o      (n_bank_addr),
    .bank_wdata_o     (n_bank_wdata),
    .bank_rdata_v_i   (n_bank_rdata_v),
    .bank_rdata_i     (n_bank_rdata)
  );

  dram_bank u_bank_n (
    .core_clk (core_clk),
    .rst_n_i  (sys_rst_n),
    .rd_lat_i (rd_lat),
    .req_i    (n_bank_req),
    .we_i     (n_bank_we),
    .addr_i   (n_bank_addr),
    .wdata_i  (n_bank_wdata),
    .rdata_v_o(n_bank_rdata_v),
    .rdata_o  (n_bank_rdata)
  );

  // south channel
  cache_dma_bridge u_bridge_s (
    .core_clk         (core_clk),
    .rst_n_i          (sys_rst_n),
    .chan_en_i        (chan_en[CHAN_S]),
    .dma_pkt_v_i      (s_dma_pkt_v_i),
    .dma_pkt_i        (s_dma_pkt_i),
    .dma_pkt_yumi_o   (s_dma_pkt_yumi_o),
    .dma_wdata_v_i    (s_dma_wdata_v_i),
    .dma_wdata_i      (s_dma_wdata_i),
    .dma_wdata_yumi_o (s_dma_wdata_yumi_o),
    .dma_rdata_v_o    (s_dma_rdata_v_o),
    .dma_rdata_o      (s_dma_rdata_o),
    .dma_rdata_ready_i(s_dma_rdata_ready_i),
    .bank_req_o       (s_bank_req),
    .bank_we_o        (s_bank_we),
    .bank_addr_o      (s_bank_addr),
    .bank_wdata_o     (s_bank_wdata),
    .bank_rdata_v_i   (s_bank_rdata_v),
    .bank_rdata_i     (s_bank_rdata)
  );

  dram_bank u_bank_s (
    .core_clk (core_clk),
    .rst_n_i  (sys_rst_n),
    .rd_lat_i (rd_lat),
    .req_i    (s_bank_req),
    .we_i     (s_bank_we),
    .addr_i   (s_bank_addr),
    .wdata_i  (s_bank_wdata),
    .rdata_v_o(s_bank_rdata_v),
    .rdata_o  (s_bank_rdata)
  );

endmodule

// File: source/dram_bank.sv
/*
  Word memory for one channel. A read returns exactly rd_lat_i cycles
  after its request, and several reads may be in flight. Changing
  rd_lat_i with reads in flight drops or repeats beats.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module dram_bank import mem_cfg_pkg::*; import cache_dma_pkg::*; (
  input  logic       core_clk,
  input  logic       rst_n_i,
  input  rd_lat_t    rd_lat_i,
  input  logic       req_i,
  input  logic       we_i,
  input  bank_addr_t addr_i,
  input  dma_word_t  wdata_i,
  output logic       rdata_v_o,
  output dma_word_t  rdata_o
);

  localparam int TAP_W = $bits(rd_lat_t);

  dma_word_t               mem [`MEM_BANK_WORDS];
  dma_word_t               d_pipe [`MEM_LAT_MAX];
  logic [`MEM_LAT_MAX-1:0] v_pipe_q;
  logic [TAP_W-1:0]        tap;

  always_ff @(posedge core_clk) begin
    if (req_i && we_i) mem[addr_i] <= wdata_i;
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      v_pipe_q <= '0;
    end else begin
      v_pipe_q <= {v_pipe_q[`MEM_LAT_MAX-2:0], req_i && !we_i};
    end
  end

  // stage 0 captures the array read, later stages just shift
  always_ff @(posedge core_clk) begin
    d_pipe[0] <= mem[addr_i];
    for (int i = 1; i < `MEM_LAT_MAX; i++) begin
      d_pipe[i] <= d_pipe[i-1];
    end
  end

  // latency 1 taps stage 0
  assign tap = (rd_lat_i == '0) ? '0 : rd_lat_i - TAP_W'(1);

  assign rdata_v_o = v_pipe_q[tap];
  assign rdata_o   = d_pipe[tap];

endmodule

// File: source/cache_dma_bridge.sv
/*
  One channel between the cache DMA port and its bank. Each packet moves
  one block in ascending word order from the block-aligned address.
  A write waits until earlier read data has left the bridge, so packets
  finish in acceptance order. Reads issue only while the read-word FIFO
  can absorb every read already in flight.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module cache_dma_bridge import cache_dma_pkg::*; (
  input  logic       core_clk,
  input  logic       rst_n_i,
  input  logic       chan_en_i,
  input  logic       dma_pkt_v_i,
  input  dma_pkt_t   dma_pkt_i,
  output logic       dma_pkt_yumi_o,
  input  logic       dma_wdata_v_i,
  input  dma_word_t  dma_wdata_i,
  output logic       dma_wdata_yumi_o,
  output logic       dma_rdata_v_o,
  output dma_word_t  dma_rdata_o,
  input  logic       dma_rdata_ready_i,
  output logic       bank_req_o,
  output logic       bank_we_o,
  output bank_addr_t bank_addr_o,
  output dma_word_t  bank_wdata_o,
  input  logic       bank_rdata_v_i,
  input  dma_word_t  bank_rdata_i
);

  localparam int BEAT_W = $clog2(`MEM_BLOCK_WORDS);
  localparam int BYTE_W = $clog2(`MEM_DATA_W/8);
  localparam int BLK_W  = $bits(bank_addr_t) - BEAT_W;
  localparam int FREE_W = $clog2(`MEM_FIFO_DEPTH+1);
  localparam int INFL_W = $clog2(`MEM_LAT_MAX+1);

  logic              pkt_push;
  logic              pkt_pop;
  logic              pkt_full;
  logic              pkt_empty;
  dma_pkt_t          head;
  logic              rd_pop;
  logic              rd_empty;
  logic [FREE_W-1:0] rd_free;
  logic [BEAT_W-1:0] beat_q;
  logic [INFL_W-1:0] inflight_q;
  logic              last_beat;
  logic              rd_idle;
  logic              wr_go;
  logic              rd_go;

  dma_fifo #(
    .payload_t(dma_pkt_t)
  ) u_pkt_fifo (
    .core_clk(core_clk),
    .rst_n_i (rst_n_i),
    .push_i  (pkt_push),
    .data_i  (dma_pkt_i),
    .full_o  (pkt_full),
    .pop_i   (pkt_pop),
    .data_o  (head),
    .empty_o (pkt_empty),
    .free_o  ()
  );

  dma_fifo #(
    .payload_t(dma_word_t)
  ) u_rd_fifo (
    .core_clk(core_clk),
    .rst_n_i (rst_n_i),
    .push_i  (bank_rdata_v_i),
    .data_i  (bank_rdata_i),
    .full_o  (),
    .pop_i   (rd_pop),
    .data_o  (dma_rdata_o),
    .empty_o (rd_empty),
    .free_o  (rd_free)
  );

  assign pkt_push       = dma_pkt_v_i && chan_en_i && !pkt_full;
  assign dma_pkt_yumi_o = pkt_push;

  // no read data left anywhere in the channel
  assign rd_idle = (inflight_q == '0) && rd_empty;

  assign wr_go = !pkt_empty && head.write_not_read && dma_wdata_v_i && rd_idle;
  assign rd_go = !pkt_empty && !head.write_not_read
              && (int'(rd_free) > int'(inflight_q));

  assign last_beat = (beat_q == BEAT_W'(`MEM_BLOCK_WORDS-1));
  assign pkt_pop   = (wr_go || rd_go) && last_beat;

  assign dma_wdata_yumi_o = wr_go;
  assign bank_req_o       = wr_go || rd_go;
  assign bank_we_o        = wr_go;
  assign bank_addr_o      = {head.addr[BYTE_W+BEAT_W +: BLK_W], beat_q};
  assign bank_wdata_o     = dma_wdata_i;

  assign dma_rdata_v_o = !rd_empty;
  assign rd_pop        = dma_rdata_v_o && dma_rdata_ready_i;

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      beat_q     <= '0;
      inflight_q <= '0;
    end else begin
      if (wr_go || rd_go) begin
        beat_q <= last_beat ? '0 : beat_q + BEAT_W'(1);
      end
      case ({rd_go, bank_rdata_v_i})
        2'b10:   inflight_q <= inflight_q + INFL_W'(1);
        2'b01:   inflight_q <= inflight_q - INFL_W'(1);
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  a_rdata_hold: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    (dma_rdata_v_o && !dma_rdata_ready_i) |=> (dma_rdata_v_o && $stable(dma_rdata_o)));

endmodule

// File: source/dma_fifo.sv
/*
  Small circular FIFO over any payload type. Push while full and pop
  while empty are illegal, even in the same cycle as the opposite side.
  Entries hold no reset value, so data_o is undefined while empty.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module dma_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `MEM_FIFO_DEPTH
) (
  input  logic                       core_clk,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  payload_t                   data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output payload_t                   data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] free_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH-1)) ? '0 : p + PTR_W'(1);
  endfunction

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign free_o  = CNT_W'(DEPTH) - count_q;

  a_no_overflow: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    !(push_i && full_o));
  a_no_underflow: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    !(pop_i && empty_o));

endmodule

// File: source/dram_cfg_regs.sv
/*
  Latency and channel-enable registers behind a four-phase req/ack port.
  The host holds we, addr and wdata while req is high. Latency writes
  saturate to 1..MEM_LAT_MAX. Change the latency only while no read is
  in flight.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module dram_cfg_regs import mem_cfg_pkg::*; (
  input  logic                   core_clk,
  input  logic                   rst_n_i,
  input  logic                   cfg_req_i,
  input  logic                   cfg_we_i,
  input  cfg_addr_t              cfg_addr_i,
  input  logic [`MEM_DATA_W-1:0] cfg_wdata_i,
  output logic                   cfg_ack_o,
  output logic [`MEM_DATA_W-1:0] cfg_rdata_o,
  output rd_lat_t                rd_lat_o,
  output chan_en_t               chan_en_o
);

  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_e;

  cfg_state_e state_q;
  rd_lat_t    rd_lat_q;
  chan_en_t   chan_en_q;
  logic       cfg_wr;

  function automatic rd_lat_t sat_lat(input logic [`MEM_DATA_W-1:0] v);
    if (v == '0) begin
      return rd_lat_t'(1);
    end else if (v > `MEM_DATA_W'(`MEM_LAT_MAX)) begin
      return rd_lat_t'(`MEM_LAT_MAX);
    end else begin
      return rd_lat_t'(v);
    end
  endfunction

  // write lands on the edge that raises ack
  assign cfg_wr = (state_q == CFG_IDLE) && cfg_req_i && cfg_we_i;

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      state_q   <= CFG_IDLE;
      rd_lat_q  <= RD_LAT_RST;
      chan_en_q <= CHAN_EN_RST;
    end else begin
      case (state_q)
        CFG_IDLE: if (cfg_req_i) state_q <= CFG_ACK;
        CFG_ACK:  if (!cfg_req_i) state_q <= CFG_IDLE;
        default:  state_q <= CFG_IDLE;
      endcase
      if (cfg_wr && cfg_addr_i == CFG_ADDR_RD_LAT) begin
        rd_lat_q <= sat_lat(cfg_wdata_i);
      end
      if (cfg_wr && cfg_addr_i == CFG_ADDR_CHAN_EN) begin
        chan_en_q <= cfg_wdata_i[$bits(chan_en_t)-1:0];
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_ADDR_RD_LAT:  cfg_rdata_o = `MEM_DATA_W'(rd_lat_q);
      CFG_ADDR_CHAN_EN: cfg_rdata_o = `MEM_DATA_W'(chan_en_q);
      default:          cfg_rdata_o = '0;
    endcase
  end

  assign cfg_ack_o = (state_q == CFG_ACK);
  assign rd_lat_o  = rd_lat_q;
  assign chan_en_o = chan_en_q;

  // host keeps req up until it sees ack
  a_req_held: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    (cfg_req_i && !cfg_ack_o) |=> cfg_req_i);

endmodule

// File: source/core_reset_ctr.sv
/*
  Reset pipeline and global cycle counter. The internal reset releases
  MEM_RESET_STAGES edges after rst_n_i rises. The counter reads 0 in the
  first cycle out of reset and wraps at 32 bits.
*/
`timescale 1ns/1ps
`include "mem_macros.svh"

module core_reset_ctr (
  input  logic        core_clk,
  input  logic        rst_n_i,
  output logic        sys_rst_n_o,
  output logic [31:0] cycle_ctr_o
);

  logic [`MEM_RESET_STAGES-1:0] rst_pipe_q;
  logic [31:0]                  ctr_q;

  always_ff @(posedge core_clk) begin
    if (!rst_n_i) begin
      rst_pipe_q <= '0;
    end else begin
      rst_pipe_q <= {rst_pipe_q[`MEM_RESET_STAGES-2:0], 1'b1};
    end
  end

  assign sys_rst_n_o = rst_pipe_q[`MEM_RESET_STAGES-1];

  always_ff @(posedge core_clk) begin
    if (!sys_rst_n_o) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 32'd1;
    end
  end

  assign cycle_ctr_o = ctr_q;

endmodule

// File: source/cache_dma_pkg.sv
/*
  DMA packet and bank types. The packet address is a byte address. Only
  the bits that select a word inside one bank are used, so higher
  address bits alias.
*/
`include "mem_macros.svh"

package cache_dma_pkg;

  typedef logic [`MEM_DATA_W-1:0] dma_word_t;

  typedef struct packed {
    logic                   write_not_read;
    logic [`MEM_ADDR_W-1:0] addr;
  } dma_pkt_t;

  // word address inside one bank
  typedef logic [$clog2(`MEM_BANK_WORDS)-1:0] bank_addr_t;

  typedef enum logic {
    CHAN_N = 1'b0,
    CHAN_S = 1'b1
  } chan_e;

endpackage

// File: source/mem_cfg_pkg.sv
/*
  Configuration register map. Two registers are mapped. Any other
  address reads as zero and drops writes.
*/
package mem_cfg_pkg;

  typedef logic [1:0] cfg_addr_t;
  typedef logic [2:0] rd_lat_t;

  // bit 0 north, bit 1 south
  typedef logic [1:0] chan_en_t;

  localparam cfg_addr_t CFG_ADDR_RD_LAT  = 2'd0;
  localparam cfg_addr_t CFG_ADDR_CHAN_EN = 2'd1;

  // values after reset
  localparam rd_lat_t  RD_LAT_RST  = 3'd1;
  localparam chan_en_t CHAN_EN_RST = 2'b11;

endpackage

// File: include/mem_macros.svh
/*
  Sizing for the memory channels. Changing MEM_DATA_W or MEM_BLOCK_WORDS
  moves the byte-offset and beat fields of the DMA address. Keep
  MEM_BLOCK_WORDS a power of two above one and MEM_LAT_MAX below 8.
*/
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// data word width in bits
`define MEM_DATA_W 32

// DMA byte address width
`define MEM_ADDR_W 14

`define MEM_BLOCK_WORDS 4
`define MEM_BANK_WORDS 1024

// bridge packet and read-word FIFOs
`define MEM_FIFO_DEPTH 2

`define MEM_RESET_STAGES 3

// largest bank read latency, cycles
`define MEM_LAT_MAX 7

`endif
